//--- bench/tb_ooo_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_core;
    import ooo_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int N_RANDOM   = 300;  // well past the 32 spare tags

    logic      clk = 1'b0;
    logic      reset = 1'b1;
    logic      issue = 1'b0;
    issue_op_t issue_op = '0;
    logic      issue_ready;
    logic      retire_valid;
    retire_t   retire;

    issue_op_t prog [$];
    retire_t   exp_q [$];
    word_t     model_regs [ARCH_REGS];
    int        n_total = 0;
    int        next_idx = 0;
    int        accepted = 0;
    int        retired = 0;
    int        div_stalls = 0;
    logic      take_next = 1'b0;

    ooo_core DUT (
        .clk(clk), .reset(reset), .issue(issue), .issue_op(issue_op),
        .issue_ready(issue_ready), .retire_valid(retire_valid), .retire(retire)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_failure();
        $display("Simulation failed");
        $fatal(1);
    endtask

    // RISC-V semantics, unsigned divide by zero included
    function automatic word_t reference_result(op_t op, word_t a, word_t b);
        logic [63:0] prod;
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
            OP_MUL: begin
                prod = {32'b0, a} * {32'b0, b};
                return prod[31:0];
            end
            OP_DIVU: return (b == 32'd0) ? 32'hffff_ffff : a / b;
            OP_REMU: return (b == 32'd0) ? a : a % b;
            default: return 32'd0;
        endcase
    endfunction

    function automatic issue_op_t make_instr(op_t op, int rd, int rs1, int rs2,
                                             int use_imm, int imm);
        issue_op_t ins;
        ins.op      = op;
        ins.rd      = arch_addr_t'(rd);
        ins.rs1     = arch_addr_t'(rs1);
        ins.rs2     = arch_addr_t'(rs2);
        ins.use_imm = (use_imm != 0);
        ins.imm     = word_t'(imm);
        return ins;
    endfunction

    function automatic issue_op_t random_instr();
        issue_op_t   ins;
        int unsigned pick;
        pick = $urandom_range(0, 99);
        if (pick < 55)      ins.op = op_t'(4'($urandom_range(0, 6)));
        else if (pick < 75) ins.op = OP_MUL;
        else if (pick < 88) ins.op = OP_DIVU;
        else                ins.op = OP_REMU;
        ins.rd      = arch_addr_t'($urandom_range(0, 7));  // narrow window, many deps
        ins.rs1     = arch_addr_t'($urandom_range(0, 15));
        ins.rs2     = arch_addr_t'($urandom_range(0, 15));
        ins.use_imm = ($urandom_range(0, 3) == 0);
        ins.imm     = ($urandom_range(0, 1) == 0) ? word_t'($urandom_range(0, 15)) : $urandom();
        return ins;
    endfunction

    task automatic load_program();
        prog.push_back(make_instr(OP_ADD, 1, 0, 0, 1, 100));
        prog.push_back(make_instr(OP_ADD, 2, 0, 0, 1, 7));
        prog.push_back(make_instr(OP_DIVU, 3, 1, 2, 0, 0));  // div feeds add feeds mul
        prog.push_back(make_instr(OP_ADD, 4, 3, 1, 0, 0));
        prog.push_back(make_instr(OP_MUL, 5, 4, 2, 0, 0));
        prog.push_back(make_instr(OP_DIVU, 6, 1, 0, 0, 0));  // divide by zero
        prog.push_back(make_instr(OP_REMU, 7, 1, 0, 0, 0));
        prog.push_back(make_instr(OP_XOR, 0, 1, 2, 0, 0));
        prog.push_back(make_instr(OP_OR, 8, 0, 2, 0, 0));
        prog.push_back(make_instr(OP_DIVU, 9, 1, 2, 0, 0));   // long op, then short ones
        prog.push_back(make_instr(OP_SUB, 10, 1, 0, 1, 3));
        prog.push_back(make_instr(OP_SLT, 11, 2, 1, 0, 0));
        for (int i = 0; i < 4; i++) begin
            prog.push_back(make_instr(OP_DIVU, 12 + i, 1, 2, 1, i + 1));
        end
        for (int i = 0; i < N_RANDOM; i++) begin
            prog.push_back(random_instr());
        end
    endtask

    task automatic model_execute(issue_op_t ins);
        word_t   a;
        word_t   b;
        retire_t want;
        a = model_regs[ins.rs1];
        b = ins.use_imm ? ins.imm : model_regs[ins.rs2];
        want.rd    = ins.rd;
        want.value = reference_result(ins.op, a, b);
        if (ins.rd != '0) model_regs[ins.rd] = want.value;
        exp_q.push_back(want);
    endtask

    task automatic check_retire();
        retire_t want;
        assert (exp_q.size() > 0) else begin
            $display("retire seen with no accepted instruction outstanding");
            report_failure();
        end
        want = exp_q.pop_front();
        assert (retire.rd == want.rd) else begin
            $display("ERR t=%0t retire.rd got=%0d expected=%0d", $time, retire.rd, want.rd);
            report_failure();
        end
        assert (retire.value == want.value) else begin
            $display("ERR t=%0t retire.value got=%08h expected=%08h",
                     $time, retire.value, want.value);
            report_failure();
        end
        retired++;
    endtask

    // outputs sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        take_next = 1'b0;
        if (!reset) begin
            if (retire_valid) check_retire();
            if (issue && issue_ready) begin
                model_execute(issue_op);
                accepted++;
                take_next = 1'b1;
            end
            if (issue && !issue_ready &&
                (issue_op.op == OP_DIVU || issue_op.op == OP_REMU)) begin
                div_stalls++;
            end
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            issue <= 1'b0;
        end else if (!issue || take_next) begin
            if (next_idx < n_total) begin
                issue_op <= prog[next_idx];
                issue    <= 1'b1;
                next_idx++;
            end else begin
                issue <= 1'b0;
            end
        end
    end

    initial begin
        void'($urandom(32'h7647dd4c));
        for (int i = 0; i < ARCH_REGS; i++) begin
            model_regs[i] = '0;
        end
        load_program();
        n_total = prog.size();
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (issue_ready && !retire_valid) else begin
            $display("outputs not in their idle state after reset");
            report_failure();
        end
        wait (retired == n_total);
        if (div_stalls > 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("divide burst never lowered issue_ready");
            report_failure();
        end
    end

    initial begin
        wait (n_total > 0);
        #((n_total * 40 + 8) * CLK_PERIOD);
        $display("watchdog expired before all instructions retired");
        report_failure();
    end

endmodule

`default_nettype wire

//--- common/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

    localparam int XLEN       = 32;
    localparam int ARCH_REGS  = 32;
    localparam int PHYS_REGS  = 64;
    localparam int ROB_DEPTH  = 16;
    localparam int DIV_STEPS  = 32;
    localparam int MUL_STEPS  = 32;
    localparam int TAG_W      = $clog2(PHYS_REGS);
    localparam int ROB_W      = $clog2(ROB_DEPTH);
    localparam int FREE_DEPTH = PHYS_REGS - ARCH_REGS; // tags outside the map
    localparam int FREE_W     = $clog2(FREE_DEPTH);
    localparam int STEP_W     = $clog2(MUL_STEPS > DIV_STEPS ? MUL_STEPS : DIV_STEPS);

    typedef logic [$clog2(ARCH_REGS)-1:0] arch_addr_t;
    typedef logic [TAG_W-1:0]             phys_tag_t;
    typedef logic [ROB_W-1:0]             rob_idx_t;
    typedef logic [XLEN-1:0]              word_t;

    typedef enum logic [3:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLTU,
        OP_MUL, OP_DIVU, OP_REMU
    } op_t;

    typedef enum logic [1:0] {UNIT_ALU, UNIT_MUL, UNIT_DIV} unit_t;

    // iterative unit sequencing
    typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_DONE} unit_state_t;

    typedef struct packed {
        op_t        op;
        arch_addr_t rd;
        arch_addr_t rs1;
        arch_addr_t rs2;
        logic       use_imm; // imm replaces rs2
        word_t      imm;
    } issue_op_t;

    typedef struct packed {
        phys_tag_t tag;
        logic      ready;
        word_t     value;
    } src_t;

    typedef struct packed {
        op_t       op;
        word_t     a;
        word_t     b;
        phys_tag_t dest;
        rob_idx_t  rob;
    } exec_op_t;

    typedef struct packed {
        logic      valid;
        phys_tag_t tag;
        rob_idx_t  rob;
        word_t     value;
    } cdb_t;

    typedef struct packed {
        arch_addr_t rd;
        word_t      value;
    } retire_t;

    function automatic unit_t op_unit(op_t op);
        case (op)
            OP_MUL:           return UNIT_MUL;
            OP_DIVU, OP_REMU: return UNIT_DIV;
            default:          return UNIT_ALU;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- compile.f
common/ooo_pkg.sv
rename/rename_map.sv
verilog/phys_regfile.sv
verilog/reserve_station.sv
exec/alu_unit.sv
exec/mul_unit.sv
exec/div_unit.sv
verilog/cdb_arbiter.sv
verilog/reorder_buffer.sv
verilog/ooo_core.sv
bench/tb_ooo_core.sv

//--- exec/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  ooo_pkg::exec_op_t exec_op,
    output logic              unit_idle,
    output logic              cdb_req,
    input  logic              cdb_grant,
    output ooo_pkg::cdb_t     result
);
    import ooo_pkg::*;

    word_t alu_out;
    cdb_t  held;

    always_comb begin
        case (exec_op.op)
            OP_ADD:  alu_out = exec_op.a + exec_op.b;
            OP_SUB:  alu_out = exec_op.a - exec_op.b;
            OP_AND:  alu_out = exec_op.a & exec_op.b;
            OP_OR:   alu_out = exec_op.a | exec_op.b;
            OP_XOR:  alu_out = exec_op.a ^ exec_op.b;
            OP_SLT:  alu_out = word_t'($signed(exec_op.a) < $signed(exec_op.b));
            OP_SLTU: alu_out = word_t'(exec_op.a < exec_op.b);
            default: alu_out = '0;
        endcase
    end

    assign cdb_req   = held.valid;
    assign unit_idle = !held.valid || cdb_grant; // slot frees as the bus takes it
    assign result    = held;

    always_ff @(posedge clk) begin
        if (reset)          held.valid <= 1'b0;
        else if (start)     held.valid <= 1'b1;
        else if (cdb_grant) held.valid <= 1'b0;

        if (start) begin
            held.tag   <= exec_op.dest;
            held.rob   <= exec_op.rob;
            held.value <= alu_out;
        end
    end

endmodule

`default_nettype wire

//--- exec/div_unit.sv
`timescale 1ns/1ps
`default_nettype none

module div_unit (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  ooo_pkg::exec_op_t exec_op,
    output logic              unit_idle,
    output logic              cdb_req,
    input  logic              cdb_grant,
    output ooo_pkg::cdb_t     result
);
    import ooo_pkg::*;

    unit_state_t       state;
    word_t             rem, quo, divisor;
    logic [XLEN:0]     rem_sh, diff;
    logic [STEP_W-1:0] step;
    logic              is_rem;
    phys_tag_t         dest_q;
    rob_idx_t          rob_q;

    // trial subtract, bit XLEN set means it went negative
    assign rem_sh = {rem, quo[XLEN-1]};
    assign diff   = rem_sh - {1'b0, divisor};

    assign cdb_req   = (state == ST_DONE);
    assign unit_idle = (state == ST_IDLE) || (cdb_req && cdb_grant);
    assign result    = cdb_t'{valid: cdb_req, tag: dest_q, rob: rob_q,
                              value: is_rem ? rem : quo};

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else if (start) begin
            state <= ST_RUN;
        end else begin
            case (state)
                ST_RUN:  if (step == '0) state <= ST_DONE;
                ST_DONE: if (cdb_grant) state <= ST_IDLE;
                default: ;
            endcase
        end

        if (start) begin
            rem     <= '0;
            quo     <= exec_op.a;  // dividend shifts out as quotient shifts in
            divisor <= exec_op.b;
            is_rem  <= (exec_op.op == OP_REMU);
            step    <= STEP_W'(DIV_STEPS - 1);
            dest_q  <= exec_op.dest;
            rob_q   <= exec_op.rob;
        end else if (state == ST_RUN) begin
            // zero divisor never goes negative, so quo ends all ones, rem = dividend
            rem  <= diff[XLEN] ? rem_sh[XLEN-1:0] : diff[XLEN-1:0];
            quo  <= {quo[XLEN-2:0], ~diff[XLEN]};
            step <= STEP_W'(step - 1);
        end
    end

endmodule

`default_nettype wire

//--- exec/mul_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mul_unit (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  ooo_pkg::exec_op_t exec_op,
    output logic              unit_idle,
    output logic              cdb_req,
    input  logic              cdb_grant,
    output ooo_pkg::cdb_t     result
);
    import ooo_pkg::*;

    unit_state_t       state;
    word_t             mcand, mplier, acc, acc_next;
    logic [STEP_W-1:0] step;
    phys_tag_t         dest_q;
    rob_idx_t          rob_q;

    assign acc_next  = mplier[0] ? acc + mcand : acc;
    assign cdb_req   = (state == ST_DONE);
    assign unit_idle = (state == ST_IDLE) || (cdb_req && cdb_grant);
    assign result    = cdb_t'{valid: cdb_req, tag: dest_q, rob: rob_q, value: acc};

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else if (start) begin
            state <= ST_RUN;
        end else begin
            case (state)
                ST_RUN:  if (step == '0) state <= ST_DONE;
                ST_DONE: if (cdb_grant) state <= ST_IDLE;
                default: ;
            endcase
        end

        if (start) begin
            acc    <= '0;
            mcand  <= exec_op.a;
            mplier <= exec_op.b;
            step   <= STEP_W'(MUL_STEPS - 1);
            dest_q <= exec_op.dest;
            rob_q  <= exec_op.rob;
        end else if (state == ST_RUN) begin
            acc    <= acc_next;
            mcand  <= mcand << 1;  // bits above XLEN never reach the low word
            mplier <= mplier >> 1;
            step   <= STEP_W'(step - 1);
        end
    end

endmodule

`default_nettype wire

//--- rename/rename_map.sv
`timescale 1ns/1ps
`default_nettype none

module rename_map (
    input  logic                clk,
    input  logic                reset,
    input  logic                alloc,
    input  ooo_pkg::arch_addr_t rs1,
    input  ooo_pkg::arch_addr_t rs2,
    input  ooo_pkg::arch_addr_t rd,
    output ooo_pkg::phys_tag_t  src1_tag,
    output ooo_pkg::phys_tag_t  src2_tag,
    output ooo_pkg::phys_tag_t  dest_tag,
    output ooo_pkg::phys_tag_t  free_tag,
    output logic                can_alloc,
    input  logic                release_en,
    input  ooo_pkg::phys_tag_t  release_tag
);
    import ooo_pkg::*;

    phys_tag_t         map_tbl [ARCH_REGS];
    phys_tag_t         free_q  [FREE_DEPTH];
    logic [FREE_W-1:0] rd_ptr, wr_ptr;
    logic [FREE_W:0]   count;

    assign src1_tag  = map_tbl[rs1];
    assign src2_tag  = map_tbl[rs2];
    assign dest_tag  = free_q[rd_ptr];   // head of free list
    // x0 writes hand back their own tag at retire
    assign free_tag  = (rd == '0) ? dest_tag : map_tbl[rd];
    assign can_alloc = (count != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_tbl[i] <= phys_tag_t'(i);
            end
            for (int i = 0; i < FREE_DEPTH; i++) begin
                free_q[i] <= phys_tag_t'(ARCH_REGS + i);
            end
            rd_ptr <= '0;
            wr_ptr <= '0;  // queue starts full
            count  <= (FREE_W + 1)'(FREE_DEPTH);
        end else begin
            if (alloc) begin
                rd_ptr <= FREE_W'(rd_ptr + 1);
                if (rd != '0) map_tbl[rd] <= dest_tag;
            end
            if (release_en) begin
                free_q[wr_ptr] <= release_tag;
                wr_ptr         <= FREE_W'(wr_ptr + 1);
            end
            count <= count + (FREE_W + 1)'(release_en) - (FREE_W + 1)'(alloc);
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module tb_ooo_core -f compile.f -o sim_ooo_core &&
./obj_dir/sim_ooo_core || exit 1

//--- verilog/cdb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter (
    input  logic          clk,
    input  logic          reset,
    input  logic [2:0]    req,
    input  ooo_pkg::cdb_t alu_res,
    input  ooo_pkg::cdb_t mul_res,
    input  ooo_pkg::cdb_t div_res,
    output logic [2:0]    grant,
    output ooo_pkg::cdb_t cdb
);
    import ooo_pkg::*;

    cdb_t       res [3];
    logic [1:0] last, pick;  // last served unit
    logic       found;

    assign res = '{alu_res, mul_res, div_res};

    // search starts one past the last winner
    always_comb begin
        int idx;
        found = 1'b0;
        pick  = last;
        for (int i = 1; i <= 3; i++) begin
            idx = (int'(last) + i) % 3;
            if (!found && req[idx]) begin
                found = 1'b1;
                pick  = 2'(idx);
            end
        end
    end

    assign grant = found ? (3'b001 << pick) : 3'b000;
    assign cdb   = found ? res[pick] : '0;

    always_ff @(posedge clk) begin
        if (reset)      last <= 2'd2;  // alu gets first pick
        else if (found) last <= pick;
    end

endmodule

`default_nettype wire

//--- verilog/ooo_core.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_core (
    input  logic                clk,
    input  logic                reset,
    input  logic                issue,
    input  ooo_pkg::issue_op_t  issue_op,
    output logic                issue_ready,
    output logic                retire_valid,
    output ooo_pkg::retire_t    retire
);
    import ooo_pkg::*;

    unit_t     tgt;
    logic      accept, can_alloc, rob_full, release_en;
    phys_tag_t src1_tag, src2_tag, new_tag, free_tag, release_tag;
    src_t      rf_src1, rf_src2, op_src2;
    rob_idx_t  alloc_idx;
    cdb_t      cdb, alu_res, mul_res, div_res;
    exec_op_t  xop [3];
    logic [2:0] st_empty, disp, idle, req, grant;

    assign tgt = op_unit(issue_op.op);
    assign issue_ready = can_alloc && !rob_full && st_empty[tgt];
    assign accept = issue && issue_ready;
    assign op_src2 = issue_op.use_imm ? src_t'{tag: '0, ready: 1'b1, value: issue_op.imm}
                                      : rf_src2;

    rename_map u_rename (
        .clk(clk), .reset(reset), .alloc(accept),
        .rs1(issue_op.rs1), .rs2(issue_op.rs2), .rd(issue_op.rd),
        .src1_tag(src1_tag), .src2_tag(src2_tag), .dest_tag(new_tag), .free_tag(free_tag),
        .can_alloc(can_alloc), .release_en(release_en), .release_tag(release_tag)
    );

    phys_regfile u_prf (
        .clk(clk), .reset(reset), .rs1_tag(src1_tag), .rs2_tag(src2_tag),
        .src1(rf_src1), .src2(rf_src2), .alloc(accept), .alloc_tag(new_tag), .cdb(cdb)
    );

    // one station per unit, indexed by unit_t
    for (genvar u = 0; u < 3; u++) begin : g_rs
        reserve_station u_rs (
            .clk(clk), .reset(reset), .load(accept && tgt == unit_t'(u)),
            .op(issue_op.op), .src1(rf_src1), .src2(op_src2),
            .dest_tag(new_tag), .rob_idx(alloc_idx), .cdb(cdb), .unit_idle(idle[u]),
            .empty(st_empty[u]), .dispatch(disp[u]), .exec_op(xop[u])
        );
    end

    alu_unit u_alu (
        .clk(clk), .reset(reset), .start(disp[UNIT_ALU]), .exec_op(xop[UNIT_ALU]),
        .unit_idle(idle[UNIT_ALU]), .cdb_req(req[UNIT_ALU]), .cdb_grant(grant[UNIT_ALU]),
        .result(alu_res)
    );

    mul_unit u_mul (
        .clk(clk), .reset(reset), .start(disp[UNIT_MUL]), .exec_op(xop[UNIT_MUL]),
        .unit_idle(idle[UNIT_MUL]), .cdb_req(req[UNIT_MUL]), .cdb_grant(grant[UNIT_MUL]),
        .result(mul_res)
    );

    div_unit u_div (
        .clk(clk), .reset(reset), .start(disp[UNIT_DIV]), .exec_op(xop[UNIT_DIV]),
        .unit_idle(idle[UNIT_DIV]), .cdb_req(req[UNIT_DIV]), .cdb_grant(grant[UNIT_DIV]),
        .result(div_res)
    );

    cdb_arbiter u_arb (
        .clk(clk), .reset(reset), .req(req),
        .alu_res(alu_res), .mul_res(mul_res), .div_res(div_res),
        .grant(grant), .cdb(cdb)
    );

    reorder_buffer u_rob (
        .clk(clk), .reset(reset), .alloc(accept), .rd(issue_op.rd), .free_tag(free_tag),
        .alloc_idx(alloc_idx), .full(rob_full), .cdb(cdb),
        .retire_valid(retire_valid), .retire(retire),
        .release_en(release_en), .release_tag(release_tag)
    );

endmodule

`default_nettype wire

//--- verilog/phys_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module phys_regfile (
    input  logic               clk,
    input  logic               reset,
    input  ooo_pkg::phys_tag_t rs1_tag,
    input  ooo_pkg::phys_tag_t rs2_tag,
    output ooo_pkg::src_t      src1,
    output ooo_pkg::src_t      src2,
    input  logic               alloc,
    input  ooo_pkg::phys_tag_t alloc_tag,
    input  ooo_pkg::cdb_t      cdb
);
    import ooo_pkg::*;

    word_t                regs [PHYS_REGS];
    logic [PHYS_REGS-1:0] ready;

    assign src1 = src_t'{tag: rs1_tag, ready: ready[rs1_tag], value: regs[rs1_tag]};
    assign src2 = src_t'{tag: rs2_tag, ready: ready[rs2_tag], value: regs[rs2_tag]};

    always_ff @(posedge clk) begin
        if (reset) begin
            ready <= '1;
            for (int i = 0; i < PHYS_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (alloc) ready[alloc_tag] <= 1'b0; // pending until broadcast
            if (cdb.valid && cdb.tag != '0) begin
                ready[cdb.tag] <= 1'b1;
                regs[cdb.tag]  <= cdb.value;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer (
    input  logic                clk,
    input  logic                reset,
    input  logic                alloc,
    input  ooo_pkg::arch_addr_t rd,
    input  ooo_pkg::phys_tag_t  free_tag,
    output ooo_pkg::rob_idx_t   alloc_idx,
    output logic                full,
    input  ooo_pkg::cdb_t       cdb,
    output logic                retire_valid,
    output ooo_pkg::retire_t    retire,
    output logic                release_en,
    output ooo_pkg::phys_tag_t  release_tag
);
    import ooo_pkg::*;

    typedef struct packed {
        arch_addr_t rd;
        phys_tag_t  free_tag;
        word_t      value;
    } rob_entry_t;

    rob_entry_t           ent [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] done;
    rob_idx_t             head, tail;
    logic [ROB_W:0]       count;

    assign alloc_idx    = tail;
    assign full         = (count == (ROB_W + 1)'(ROB_DEPTH));
    assign retire_valid = (count != '0) && done[head];  // oldest only
    assign retire       = retire_t'{rd: ent[head].rd, value: ent[head].value};
    assign release_en   = retire_valid;
    assign release_tag  = ent[head].free_tag;

    always_ff @(posedge clk) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            if (alloc) begin
                done[tail] <= 1'b0;
                tail       <= rob_idx_t'(tail + 1);
            end
            if (cdb.valid) done[cdb.rob] <= 1'b1;
            if (retire_valid) head <= rob_idx_t'(head + 1);
            count <= count + (ROB_W + 1)'(alloc) - (ROB_W + 1)'(retire_valid);
        end

        if (alloc) begin
            ent[tail].rd       <= rd;
            ent[tail].free_tag <= free_tag;
        end
        if (cdb.valid) ent[cdb.rob].value <= cdb.value;
    end

endmodule

`default_nettype wire

//--- verilog/reserve_station.sv
`timescale 1ns/1ps
`default_nettype none

module reserve_station (
    input  logic               clk,
    input  logic               reset,
    input  logic               load,
    input  ooo_pkg::op_t       op,
    input  ooo_pkg::src_t      src1,
    input  ooo_pkg::src_t      src2,
    input  ooo_pkg::phys_tag_t dest_tag,
    input  ooo_pkg::rob_idx_t  rob_idx,
    input  ooo_pkg::cdb_t      cdb,
    input  logic               unit_idle,
    output logic               empty,
    output logic               dispatch,
    output ooo_pkg::exec_op_t  exec_op
);
    import ooo_pkg::*;

    logic      valid;
    op_t       op_q;
    src_t      s1, s2;
    phys_tag_t dest_q;
    rob_idx_t  rob_q;

    // pick up a broadcast value for a waiting operand
    function automatic src_t wake(src_t s, cdb_t c);
        src_t r;
        r = s;
        if (!s.ready && c.valid && c.tag == s.tag) begin
            r.ready = 1'b1;
            r.value = c.value;
        end
        return r;
    endfunction

    assign empty    = !valid;
    assign dispatch = valid && s1.ready && s2.ready && unit_idle;
    assign exec_op  = exec_op_t'{op: op_q, a: s1.value, b: s2.value, dest: dest_q, rob: rob_q};

    always_ff @(posedge clk) begin
        if (reset)         valid <= 1'b0;
        else if (load)     valid <= 1'b1;
        else if (dispatch) valid <= 1'b0;

        if (load) begin
            op_q   <= op;
            s1     <= wake(src1, cdb);  // same-cycle broadcast
            s2     <= wake(src2, cdb);
            dest_q <= dest_tag;
            rob_q  <= rob_idx;
        end else if (valid) begin
            s1 <= wake(s1, cdb);
            s2 <= wake(s2, cdb);
        end
    end

endmodule

`default_nettype wire
